//--- dual_mode_sa.f
+incdir+.
sa_pkg.sv
sa_operand_pack.sv
sa_pe.sv
sa_array.sv
sa_readout.sv
sa_top.sv
sa_asserts.sv
sa_tb.sv

//--- sa_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_array
    import sa_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         acc_clear,
    input  logic                                         en,
    input  logic                                         mode,
    input  logic [`SA_COL_NUM-1:0][`SA_OPA_W-1:0]        opa,
    input  logic [`SA_ROW_NUM-1:0][`SA_OPB_W-1:0]        opb,
    output pe_result_u [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] results
);

    // registered operands leaving each cell
    logic [`SA_OPA_W-1:0] down_w  [`SA_ROW_NUM][`SA_COL_NUM];
    logic [`SA_OPB_W-1:0] right_w [`SA_ROW_NUM][`SA_COL_NUM];

    //////////////////////////////
    // cell grid
    //////////////////////////////

    for (genvar i = 0; i < `SA_ROW_NUM; i++) begin : g_row
        for (genvar j = 0; j < `SA_COL_NUM; j++) begin : g_col
            logic [`SA_OPA_W-1:0] pe_up;
            logic [`SA_OPB_W-1:0] pe_left;

            // pixels come down the columns
            if (i == 0) begin : g_top
                assign pe_up = opa[j];
            end else begin : g_below
                assign pe_up = down_w[i-1][j];
            end

            // weights move right along the rows
            if (j == 0) begin : g_edge
                assign pe_left = opb[i];
            end else begin : g_inner
                assign pe_left = right_w[i][j-1];
            end

            sa_pe u_pe (
                .clk       (clk),
                .acc_clear (acc_clear),
                .en        (en),
                .mode      (mode),
                .up        (pe_up),
                .left      (pe_left),
                .bottom    (down_w[i][j]),
                .right     (right_w[i][j]),
                .result    (results[i][j])
            );
        end
    end

endmodule

`default_nettype wire

//--- sa_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_asserts (
    input logic                                   clk,
    input logic                                   channel_out_reset,
    input logic                                   channel_out_en,
    input logic [`SA_PE_OUT_W*`SA_COL_NUM-1:0]     out
);

    int   err_count = 0;     // read by the testbench at the end
    logic idle_q    = 1'b0;  // counter idle since the last reset

    always_ff @(posedge clk) begin
        if (channel_out_reset)
            idle_q <= 1'b1;
        else if (channel_out_en)
            idle_q <= 1'b0;
    end

    //////////////////////////////
    // readout port checks
    //////////////////////////////

    a_zero_after_reset: assert property (@(posedge clk) channel_out_reset |=> out == '0)
        else begin
            $error("out not zero in the cycle after channel_out_reset");
            err_count++;
        end

    a_zero_when_idle: assert property (@(posedge clk) idle_q |-> out == '0)
        else begin
            $error("out not zero while the row counter is idle");
            err_count++;
        end

    a_no_x: assert property (@(posedge clk) !channel_out_reset |-> !$isunknown(out))
        else begin
            $error("out has X or Z bits outside reset");
            err_count++;
        end

endmodule

bind sa_top sa_asserts u_asserts (
    .clk               (clk),
    .channel_out_reset (channel_out_reset),
    .channel_out_en    (channel_out_en),
    .out               (out)
);

`default_nettype wire

//--- sa_consts.svh
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

//////////////////////////////
// array geometry
//////////////////////////////

`define SA_ROW_NUM 4
`define SA_COL_NUM 4

//////////////////////////////
// lane and operand widths
//////////////////////////////

// extra bits above one product, so sums can grow
`define SA_HEADROOM 8

`define SA_LANE88_W (16 + `SA_HEADROOM)   // 8b pixel x 8b weight lanes
`define SA_LANE18_W (8 + `SA_HEADROOM)    // 8b pixel x 1b weight lanes

`define SA_PE_OUT_W 64                    // one cell result word

`define SA_OPA_W 24                       // two pixels, packed
`define SA_OPB_W 18                       // one or two weights, packed

// idle value is all ones, so one spare code above the rows
`define SA_ROWCNT_W ($clog2(`SA_ROW_NUM + 1))

`endif

//--- sa_operand_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_operand_pack (
    input  logic                                  mode,
    input  logic [8*`SA_ROW_NUM-1:0]              row_in,      // one weight byte per row
    input  logic [16*`SA_COL_NUM-1:0]             column_in,   // two pixels per column
    output logic [`SA_COL_NUM-1:0][`SA_OPA_W-1:0] opa,
    output logic [`SA_ROW_NUM-1:0][`SA_OPB_W-1:0] opb
);

    //////////////////////////////
    // pixel operands
    //////////////////////////////

    // hi pixel goes up by 16 (mode 0) or 8 (mode 1), lo pixel sign extended
    always_comb begin : pack_pixels
        logic [7:0] px_hi;
        logic [7:0] px_lo;
        for (int j = 0; j < `SA_COL_NUM; j++) begin
            px_hi = column_in[16*j+8 +: 8];
            px_lo = column_in[16*j +: 8];
            if (!mode) begin
                opa[j] = {px_hi, 16'h0000}
                       + {{(`SA_OPA_W-8){px_lo[7]}}, px_lo};
            end else begin
                opa[j] = {{8{px_hi[7]}}, px_hi, 8'h00}
                       + {{(`SA_OPA_W-8){px_lo[7]}}, px_lo};
            end
        end
    end

    //////////////////////////////
    // weight operands
    //////////////////////////////

    // mode 1 bit value 1 means -1
    always_comb begin : pack_weights
        logic [7:0] wt;
        for (int i = 0; i < `SA_ROW_NUM; i++) begin
            wt = row_in[8*i +: 8];
            if (!mode) begin
                opb[i] = {{(`SA_OPB_W-8){wt[7]}}, wt};   // plain signed byte
            end else begin
                // w1 at bit 16, w0 at bit 0, each +1 or -1
                opb[i] = {wt[1], 1'b1, 16'h0000}
                       + {{(`SA_OPB_W-1){wt[0]}}, 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- sa_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_pe
    import sa_pkg::*;
(
    input  logic                 clk,
    input  logic                 acc_clear,
    input  logic                 en,
    input  logic                 mode,
    input  logic [`SA_OPA_W-1:0] up,       // packed pixels from above
    input  logic [`SA_OPB_W-1:0] left,     // packed weights from the left
    output logic [`SA_OPA_W-1:0] bottom,
    output logic [`SA_OPB_W-1:0] right,
    output pe_result_u           result
);

    localparam int L88    = `SA_LANE88_W;
    localparam int L18    = `SA_LANE18_W;
    localparam int PROD_W = `SA_OPA_W + 1 + `SA_OPB_W;

    logic                     a_sign;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] rem0;
    logic signed [PROD_W-1:0] rem1;
    logic signed [PROD_W-1:0] rem2;
    logic signed [PROD_W-1:0] rem3;
    logic signed [15:0]       m0_p [2];
    logic signed [8:0]        m1_p [4];
    pe_result_u               acc;

    // 8b field of a +-1 product; 0x80 is +128 when the weight is -1
    function automatic logic signed [8:0] field9(input logic [7:0] f, input logic w_neg);
        if (f == 8'h80 && w_neg)
            field9 = 9'sd128;
        else
            field9 = {f[7], f};
    endfunction

    //////////////////////////////
    // packed multiply and split
    //////////////////////////////

    always_comb begin
        // mode 0 packing wraps past bit 23 for hi = -128 with lo < 0
        a_sign = up[`SA_OPA_W-1] | (~mode & (up[23:16] == 8'h7f) & up[15]);
        prod   = $signed({a_sign, up}) * $signed(left);

        // mode 0: lo*w in the low 16 bits, hi*w above it after the borrow
        m0_p[0] = prod[15:0];
        rem0    = (prod - m0_p[0]) >>> 16;
        m0_p[1] = rem0[15:0];

        // mode 1: four fields 8 bits apart, peeled from the bottom
        m1_p[0] = field9(prod[7:0], left[1]);              // lo*w0
        rem1    = (prod - m1_p[0]) >>> 8;
        m1_p[1] = field9(rem1[7:0], left[1]);              // hi*w0
        rem2    = (rem1 - m1_p[1]) >>> 8;
        m1_p[2] = field9(rem2[7:0], left[`SA_OPB_W-1]);    // lo*w1
        rem3    = (rem2 - m1_p[2]) >>> 8;
        m1_p[3] = rem3[8:0];                               // hi*w1, what is left
    end

    //////////////////////////////
    // pass regs and accumulator
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (acc_clear) begin
            bottom <= '0;
            right  <= '0;
            acc    <= '0;
        end else if (en) begin
            bottom <= up;
            right  <= left;
            if (!mode) begin
                acc.m88.unused <= '0;
                for (int k = 0; k < 2; k++) begin
                    acc.m88.lane[k] <= acc.m88.lane[k] + L88'(m0_p[k]);
                end
            end else begin
                for (int k = 0; k < 4; k++) begin
                    acc.m18.lane[k] <= acc.m18.lane[k] + L18'(m1_p[k]);
                end
            end
        end
    end

    assign result = acc;

endmodule

`default_nettype wire

//--- sa_pkg.sv
`default_nettype none

`include "sa_consts.svh"

package sa_pkg;

    //////////////////////////////
    // cell result word
    //////////////////////////////

    // same 64 bits, read by mode
    typedef union packed {
        // mode 0: lane k = pixel k times the 8b weight
        struct packed {
            logic [`SA_PE_OUT_W-2*`SA_LANE88_W-1:0] unused;   // kept at zero
            logic [1:0][`SA_LANE88_W-1:0]           lane;
        } m88;
        // mode 1: lane k = pixel k%2 times weight k/2
        struct packed {
            logic [3:0][`SA_LANE18_W-1:0] lane;
        } m18;
    } pe_result_u;

endpackage

`default_nettype wire

//--- sa_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_readout
    import sa_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        channel_out_reset,
    input  logic                                        channel_out_en,
    input  logic                                        mode,
    input  pe_result_u [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] results,
    output logic [`SA_PE_OUT_W*`SA_COL_NUM-1:0]          out
);

    localparam int L88_PAIR = 2 * `SA_LANE88_W;
    localparam int L18_PAIR = 2 * `SA_LANE18_W;
    // idle code (all ones) is also past this
    localparam logic [`SA_ROWCNT_W-1:0] ROW_END = (`SA_ROWCNT_W)'(`SA_ROW_NUM);

    logic [`SA_ROWCNT_W-1:0]         row_cnt;
    logic                            row_valid;
    pe_result_u [`SA_COL_NUM-1:0]    row_words;

    //////////////////////////////
    // row counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset)
            row_cnt <= '1;                     // idle
        else if (channel_out_en)
            row_cnt <= row_cnt + 1'b1;         // idle steps to row 0
    end

    assign row_valid = (row_cnt < ROW_END);

    //////////////////////////////
    // row select and format
    //////////////////////////////

    always_comb begin
        row_words = '0;
        if (row_valid)
            row_words = results[row_cnt];
    end

    // mode 0: 48b per column; mode 1: lanes 0/1 low half, lanes 2/3 high half
    always_comb begin
        out = '0;
        for (int j = 0; j < `SA_COL_NUM; j++) begin
            if (!mode) begin
                out[L88_PAIR*j +: L88_PAIR] = row_words[j].m88.lane;
            end else begin
                out[L18_PAIR*j +: L18_PAIR] = row_words[j].m18.lane[1:0];
                out[L18_PAIR*`SA_COL_NUM + L18_PAIR*j +: L18_PAIR] =
                    row_words[j].m18.lane[3:2];
            end
        end
    end

endmodule

`default_nettype wire

//--- sa_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_tb;

    localparam int R     = `SA_ROW_NUM;
    localparam int C     = `SA_COL_NUM;
    localparam int OUT_W = `SA_PE_OUT_W * `SA_COL_NUM;

    logic             clk = 1'b0;
    logic             channel_out_reset;
    logic             acc_clear;
    logic             en;
    logic             mode;
    logic             channel_out_en;
    logic [8*R-1:0]   row_in;
    logic [16*C-1:0]  column_in;
    logic [OUT_W-1:0] out;
    logic [31:0]      seed = 32'hac5a_1059;

    // inputs of every enabled cycle since the last clear
    logic [16*C-1:0]  col_hist [$];
    logic [8*R-1:0]   row_hist [$];

    sa_top dut (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .acc_clear         (acc_clear),
        .en                (en),
        .mode              (mode),
        .channel_out_en    (channel_out_en),
        .row_in            (row_in),
        .column_in         (column_in),
        .out               (out)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // one lane product with weight bit value 1 as -1 in mode 1
    function automatic int lane_prod(input logic m, input int l, input logic [15:0] px2,
                                     input logic [7:0] wt);
        int px;
        px = (l % 2 == 1) ? $signed(px2[15:8]) : $signed(px2[7:0]);
        if (!m)
            return px * int'($signed(wt));
        return wt[l/2] ? -px : px;
    endfunction

    // expected out for row r with pixel from k-i and weight from k-j
    function automatic logic [OUT_W-1:0] model_row(input int r);
        logic [OUT_W-1:0] v;
        logic [16*C-1:0]  cw;
        logic [8*R-1:0]   rw;
        int               sum;
        v = '0;
        for (int j = 0; j < C; j++) begin
            for (int l = 0; l < (mode ? 4 : 2); l++) begin
                sum = 0;
                for (int k = 0; k < col_hist.size(); k++) begin
                    if (k - r >= 0 && k - j >= 0) begin
                        cw = col_hist[k-r];
                        rw = row_hist[k-j];
                        sum += lane_prod(mode, l, cw[16*j +: 16], rw[8*r +: 8]);
                    end
                end
                if (!mode)
                    v[48*j + 24*l +: 24] = sum[23:0];
                else if (l < 2)
                    v[32*j + 16*l +: 16] = sum[15:0];
                else
                    v[32*C + 32*j + 16*(l-2) +: 16] = sum[15:0];
            end
        end
        return v;
    endfunction

    //////////////////////////////
    // drive and check helpers
    //////////////////////////////

    task automatic check_out(input string what, input logic [OUT_W-1:0] exp);
        assert (out === exp) else begin
            $display("ERR out (%s) exp %h got %h", what, exp, out);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic clear_acc();
        @(posedge clk);
        acc_clear <= 1'b1;
        @(posedge clk);
        acc_clear <= 1'b0;
        col_hist.delete();
        row_hist.delete();
    endtask

    task automatic feed(input logic [16*C-1:0] col, input logic [8*R-1:0] row);
        @(posedge clk);
        en        <= 1'b1;
        column_in <= col;
        row_in    <= row;
        col_hist.push_back(col);
        row_hist.push_back(row);
    endtask

    // inputs change with en low and must be ignored
    task automatic hold(input int n);
        @(posedge clk);
        en        <= 1'b0;
        column_in <= {$random(seed), $random(seed)};
        row_in    <= $random(seed);
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic flush();
        for (int k = 0; k < R + C; k++)
            feed('0, '0);
        @(posedge clk);
        en <= 1'b0;
    endtask

    task automatic reset_readout();
        @(posedge clk);
        channel_out_reset <= 1'b1;
        @(posedge clk);
        channel_out_reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic step_row();
        @(posedge clk);
        channel_out_en <= 1'b1;
        @(posedge clk);
        channel_out_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_readout();
        reset_readout();
        for (int r = 0; r < R; r++) begin
            step_row();
            check_out($sformatf("row %0d", r), model_row(r));
        end
    endtask

    // first cycles hit the pixel and weight extremes
    task automatic stream_random(input int n, input int gap_at, input int gap_len);
        for (int k = 0; k < n; k++) begin
            if (k == gap_at)
                hold(gap_len);
            if (k == 0)
                feed({C{16'h8080}}, {R{8'h80}});
            else if (k == 1)
                feed({C{16'h7f7f}}, {R{8'h80}});
            else if (k == 2)
                feed({C{16'h80ff}}, {R{8'h7f}});
            else if (k == 3)
                feed({C{16'h8080}}, {R{8'hff}});   // -128 times -1 in every field
            else
                feed({$random(seed), $random(seed)}, $random(seed));
        end
        flush();
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset_clear();
        check_out("after reset", '0);
        clear_acc();
        check_readout();
    endtask

    task automatic test_single_pulse();
        clear_acc();
        feed({$random(seed), $random(seed)}, $random(seed));
        flush();
        check_readout();
    endtask

    task automatic test_stream(input logic m);
        @(posedge clk);
        mode <= m;
        clear_acc();
        stream_random(20, -1, 0);
        check_readout();
    endtask

    task automatic test_readout_ctrl();
        reset_readout();
        step_row();
        step_row();
        repeat (3) begin
            @(negedge clk);
            check_out("held row 1", model_row(1));   // no channel_out_en
        end
        step_row();
        step_row();
        check_out("row 3", model_row(3));
        reset_readout();
        check_out("idle after reset", '0);          // left row 3
        check_readout();                              // results untouched
        step_row();
        check_out("past last row", '0);
    endtask

    task automatic test_hold_clear();
        @(posedge clk);
        mode <= 1'b0;
        clear_acc();
        stream_random(10, 5, 4);
        check_readout();
        clear_acc();
        feed({$random(seed), $random(seed)}, $random(seed));
        flush();
        check_readout();
    endtask

    initial begin
        channel_out_reset = 1'b1;
        acc_clear         = 1'b0;
        en                = 1'b0;
        mode              = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        repeat (3) @(posedge clk);
        channel_out_reset <= 1'b0;
        @(negedge clk);

        test_reset_clear();
        test_single_pulse();
        test_stream(1'b0);
        test_stream(1'b1);
        test_readout_ctrl();
        test_hold_clear();

        repeat (2) @(posedge clk);
        if (dut.u_asserts.err_count != 0) begin
            $display("bound checker reported %0d failures", dut.u_asserts.err_count);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (20000) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("*** FAILED ***");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- sa_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_consts.svh"

module sa_top
    import sa_pkg::*;
(
    input  logic                               clk,
    input  logic                               channel_out_reset,
    input  logic                               acc_clear,
    input  logic                               en,
    input  logic                               mode,            // 0: 8b weights, 1: +-1 weights
    input  logic                               channel_out_en,
    input  logic [8*`SA_ROW_NUM-1:0]           row_in,
    input  logic [16*`SA_COL_NUM-1:0]          column_in,
    output logic [`SA_PE_OUT_W*`SA_COL_NUM-1:0] out
);

    logic [`SA_COL_NUM-1:0][`SA_OPA_W-1:0]         opa;
    logic [`SA_ROW_NUM-1:0][`SA_OPB_W-1:0]         opb;
    pe_result_u [`SA_ROW_NUM-1:0][`SA_COL_NUM-1:0] results;

    //////////////////////////////
    // edge packing, grid, readout
    //////////////////////////////

    sa_operand_pack u_pack (
        .mode      (mode),
        .row_in    (row_in),
        .column_in (column_in),
        .opa       (opa),
        .opb       (opb)
    );

    sa_array u_array (
        .clk       (clk),
        .acc_clear (acc_clear),
        .en        (en),
        .mode      (mode),
        .opa       (opa),
        .opb       (opb),
        .results   (results)
    );

    sa_readout u_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .mode              (mode),
        .results           (results),
        .out               (out)
    );

endmodule

`default_nettype wire
